//--- kc_periph_top.f
source/kc_periph_pkg.sv
source/periph_addr_decode.sv
source/gpio_regs.sv
source/uart_tx_engine.sv
source/wb_read_return.sv
source/kc_periph_top.sv
test/kc_periph_assertions.sv
test/tb_kc_periph_top.sv

//--- Makefile
# Verilator build and run of the kc_periph_top testbench

TOP := tb_kc_periph_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f kc_periph_top.f -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@grep -q -x -F '** PASS **' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f kc_periph_top.f

clean:
	rm -rf obj_dir $(LOG)

//--- test/tb_kc_periph_top.sv
// Testbench for kc_periph_top with bus tasks, UART receiver, compare tasks and directed tests
`timescale 1ns/100ps

module tb_kc_periph_top;
  import kc_periph_pkg::*;

  typedef enum logic [1:0] {RESP_NONE, RESP_ACK, RESP_ERR} resp_e;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int BUS_LIMIT    = 1000;
  localparam int TEST_DIV     = 5;
  localparam int BIT_CLKS     = TEST_DIV + 1;
  // 43 bus transfers of up to 3 clocks and 3 UART frames
  localparam int N_XFERS      = 43;
  localparam int N_FRAMES     = 3;
  localparam int WATCHDOG_NS  =
    2 * (RESET_CYCLES + N_XFERS * 3 + N_FRAMES * UART_FRAME_BITS * BIT_CLKS) * CLK_PERIOD;

  logic              clk;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [WB_AW-1:0]  wb_adr;
  logic [WB_DW-1:0]  wb_wdat;
  logic [WB_DW-1:0]  wb_rdat;
  logic              wb_ack;
  logic              wb_err;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_dir;
  logic              uart_td;
  logic [31:0]       lfsr;
  logic [GPIO_W-1:0] exp_out;
  logic [GPIO_W-1:0] exp_dir;
  int                error_count;
  int                test_count;
  time               resp_time;
  time               rx_start_time;

  kc_periph_top i_dut (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_wb_cyc   (wb_cyc),
    .i_wb_stb   (wb_stb),
    .i_wb_we    (wb_we),
    .i_wb_adr   (wb_adr),
    .i_wb_dat   (wb_wdat),
    .o_wb_dat   (wb_rdat),
    .o_wb_ack   (wb_ack),
    .o_wb_err   (wb_err),
    .i_gpio     (gpio_in),
    .o_gpio     (gpio_out),
    .o_gpio_dir (gpio_dir),
    .o_uart_td  (uart_td)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

  // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic gpio_word_u pins_word(input logic [GPIO_W-1:0] pins);
    gpio_word_u w;
    w.raw         = '0;
    w.fields.leds = pins[GPIO_W-1:DIP_W];
    w.fields.dips = pins[DIP_W-1:0];
    return w;
  endfunction

  task automatic check_word(input logic [WB_DW-1:0] got, input logic [WB_DW-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_gpio(input gpio_word_u got, input gpio_word_u exp, input string what);
    if (got.raw !== exp.raw) begin
      $display("** Error at %0t: %s is rsvd %h leds %h dips %h, expected leds %h dips %h",
               $time, what, got.fields.rsvd, got.fields.leds, got.fields.dips,
               exp.fields.leds, exp.fields.dips);
      error_count++;
    end
  endtask

  task automatic check_resp(input resp_e got, input resp_e exp, input string what);
    if (got != exp) begin
      $display("** Error at %0t: %s ended with %s, expected %s", $time, what, got.name(),
               exp.name());
      error_count++;
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_line(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  // Called on a falling edge, returns on a falling edge with the bus released
  task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                           input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat,
                           output resp_e resp);
    int waited;
    waited  = 0;
    resp    = RESP_NONE;
    rdat    = '0;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = wdat;
    while ((resp == RESP_NONE) && (waited < BUS_LIMIT)) begin
      @(negedge clk);
      waited++;
      if (wb_ack) begin
        resp = RESP_ACK;
      end else if (wb_err) begin
        resp = RESP_ERR;
      end
    end
    if (resp == RESP_NONE) begin
      $display("Transfer to address %h got neither ack nor err within %0d cycles", adr,
               BUS_LIMIT);
      error_count++;
    end
    rdat      = wb_rdat;
    resp_time = $time;
    // Response is taken on the next rising edge
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat,
                          output resp_e resp);
    logic [WB_DW-1:0] rd;
    bus_cycle(1'b1, adr, dat, rd, resp);
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat,
                         output resp_e resp);
    bus_cycle(1'b0, adr, '0, dat, resp);
  endtask

  // Samples each bit near its middle, starting from the falling edge of the start bit
  task automatic uart_rx(output logic [7:0] data);
    int waited;
    int b;
    data   = '0;
    waited = 0;
    while (uart_td && (waited < BUS_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    if (uart_td) begin
      $display("No UART start bit seen within %0d cycles", BUS_LIMIT);
      error_count++;
    end else begin
      rx_start_time = $time;
      repeat (BIT_CLKS / 2 - 1) @(negedge clk);
      check_line(uart_td, 1'b0, "UART start bit");
      for (b = 0; b < 8; b++) begin
        repeat (BIT_CLKS) @(negedge clk);
        data[b] = uart_td;
      end
      repeat (BIT_CLKS) @(negedge clk);
      check_line(uart_td, 1'b1, "UART stop bit");
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("Test %0d %s finished with %0d errors", test_count, name,
             error_count - errs_before);
  endtask

  task automatic reset_values();
    logic [WB_DW-1:0] rd;
    resp_e resp;
    int errs;
    errs = error_count;
    check_line(uart_td, 1'b1, "UART line after reset");
    check_gpio(pins_word(gpio_out), pins_word('0), "o_gpio after reset");
    check_gpio(pins_word(gpio_dir), pins_word('0), "o_gpio_dir after reset");
    wb_read(REG_GPIO_OUT, rd, resp);
    check_resp(resp, RESP_ACK, "GPIO_OUT read");
    check_gpio(rd, pins_word('0), "GPIO_OUT reset value");
    wb_read(REG_GPIO_DIR, rd, resp);
    check_resp(resp, RESP_ACK, "GPIO_DIR read");
    check_gpio(rd, pins_word('0), "GPIO_DIR reset value");
    wb_read(REG_UART_STATUS, rd, resp);
    check_resp(resp, RESP_ACK, "STATUS read");
    check_word(rd, 32'h0, "STATUS reset value");
    wb_read(REG_UART_DIV, rd, resp);
    check_resp(resp, RESP_ACK, "DIV read");
    check_word(rd, {16'h0, UART_DIV_RESET}, "DIV reset value");
    report_test("reset values", errs);
  endtask

  task automatic gpio_out_dir();
    logic [WB_DW-1:0] v_out;
    logic [WB_DW-1:0] v_dir;
    logic [WB_DW-1:0] rd;
    resp_e resp;
    int errs;
    int i;
    errs = error_count;
    for (i = 0; i < 4; i++) begin
      v_out = rand_bits(32);
      v_dir = rand_bits(32);
      wb_write(REG_GPIO_OUT, v_out, resp);
      check_resp(resp, RESP_ACK, "GPIO_OUT write");
      wb_write(REG_GPIO_DIR, v_dir, resp);
      check_resp(resp, RESP_ACK, "GPIO_DIR write");
      exp_out = v_out[GPIO_W-1:0];
      exp_dir = v_dir[GPIO_W-1:0];
      check_gpio(pins_word(gpio_out), pins_word(exp_out), "o_gpio");
      check_gpio(pins_word(gpio_dir), pins_word(exp_dir), "o_gpio_dir");
      wb_read(REG_GPIO_OUT, rd, resp);
      check_gpio(rd, pins_word(exp_out), "GPIO_OUT readback");
      wb_read(REG_GPIO_DIR, rd, resp);
      check_gpio(rd, pins_word(exp_dir), "GPIO_DIR readback");
    end
    report_test("GPIO output and direction", errs);
  endtask

  task automatic gpio_input();
    gpio_word_u pins;
    logic [31:0] t;
    logic [WB_DW-1:0] rd;
    resp_e resp;
    int errs;
    int i;
    errs = error_count;
    for (i = 0; i < 4; i++) begin
      pins.raw         = '0;
      t                = rand_bits(LED_W);
      pins.fields.leds = t[LED_W-1:0];
      t                = rand_bits(DIP_W);
      pins.fields.dips = t[DIP_W-1:0];
      gpio_in          = {pins.fields.leds, pins.fields.dips};
      // Outputs differ from the pins so a read of the wrong register shows
      exp_out = ~gpio_in;
      wb_write(REG_GPIO_OUT, {20'h0, exp_out}, resp);
      repeat (3) @(negedge clk);
      wb_read(REG_GPIO_IN, rd, resp);
      check_resp(resp, RESP_ACK, "GPIO_IN read");
      check_gpio(rd, pins, "GPIO_IN");
    end
    report_test("GPIO input", errs);
  endtask

  task automatic uart_frame();
    logic [WB_DW-1:0] rd;
    logic [31:0] t;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    resp_e resp;
    resp_e resp_st;
    int errs;
    errs = error_count;
    wb_write(REG_UART_DIV, TEST_DIV, resp);
    check_resp(resp, RESP_ACK, "DIV write");
    t       = rand_bits(8);
    tx_byte = t[7:0];
    fork
      begin
        wb_write(REG_UART_TXDATA, {24'h0, tx_byte}, resp);
        wb_read(REG_UART_STATUS, rd, resp_st);
      end
      uart_rx(rx_byte);
    join
    check_resp(resp, RESP_ACK, "TXDATA write");
    check_resp(resp_st, RESP_ACK, "STATUS read");
    check_word(rd, 32'h1, "STATUS during frame");
    check_byte(rx_byte, tx_byte, "received byte");
    repeat (BIT_CLKS) @(negedge clk);
    wb_read(REG_UART_STATUS, rd, resp);
    check_word(rd, 32'h0, "STATUS after frame");
    report_test("UART frame", errs);
  endtask

  task automatic uart_backpressure();
    logic [WB_DW-1:0] rd;
    logic [31:0] t;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] g1;
    logic [7:0] g2;
    resp_e r1;
    resp_e r2;
    time busy_end;
    time ack2_time;
    int errs;
    errs = error_count;
    t  = rand_bits(16);
    b1 = t[7:0];
    b2 = t[15:8];
    fork
      begin
        wb_write(REG_UART_TXDATA, {24'h0, b1}, r1);
        wb_write(REG_UART_TXDATA, {24'h0, b2}, r2);
        ack2_time = resp_time;
      end
      begin
        uart_rx(g1);
        // First frame is busy for 10 bit times from its start bit
        busy_end = rx_start_time + UART_FRAME_BITS * BIT_CLKS * CLK_PERIOD;
        uart_rx(g2);
      end
    join
    check_resp(r1, RESP_ACK, "first TXDATA write");
    check_resp(r2, RESP_ACK, "second TXDATA write");
    if (ack2_time <= busy_end) begin
      $display("Second TXDATA write was acknowledged while the first frame was still busy");
      error_count++;
    end else if (ack2_time != busy_end + CLK_PERIOD) begin
      $display("Second TXDATA ack came later than one clock after the first frame");
      error_count++;
    end
    check_byte(g1, b1, "first received byte");
    check_byte(g2, b2, "second received byte");
    repeat (BIT_CLKS) @(negedge clk);
    wb_read(REG_UART_STATUS, rd, r1);
    check_word(rd, 32'h0, "STATUS after both frames");
    report_test("UART back-pressure", errs);
  endtask

  task automatic bus_errors();
    logic [WB_DW-1:0] rd;
    resp_e resp;
    int errs;
    errs = error_count;
    wb_write(8'h0C, rand_bits(32), resp);
    check_resp(resp, RESP_ERR, "write to 0x0C");
    wb_write(8'h05, rand_bits(32), resp);
    check_resp(resp, RESP_ERR, "write to misaligned 0x05");
    wb_read(8'h40, rd, resp);
    check_resp(resp, RESP_ERR, "read of 0x40");
    wb_write(REG_GPIO_IN, rand_bits(32), resp);
    check_resp(resp, RESP_ERR, "write to GPIO_IN");
    wb_write(REG_UART_STATUS, 32'h1, resp);
    check_resp(resp, RESP_ERR, "write to STATUS");
    wb_read(REG_GPIO_OUT, rd, resp);
    check_gpio(rd, pins_word(exp_out), "GPIO_OUT after bus errors");
    wb_read(REG_GPIO_DIR, rd, resp);
    check_gpio(rd, pins_word(exp_dir), "GPIO_DIR after bus errors");
    wb_read(REG_UART_DIV, rd, resp);
    check_word(rd, TEST_DIV, "DIV after bus errors");
    report_test("bus errors", errs);
  endtask

  initial begin
    lfsr          = 32'hcdb57263;
    error_count   = 0;
    test_count    = 0;
    resp_time     = 0;
    rx_start_time = 0;
    exp_out       = '0;
    exp_dir       = '0;
    rst_n         = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_wdat       = '0;
    gpio_in       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_values();
    gpio_out_dir();
    gpio_input();
    uart_frame();
    uart_backpressure();
    bus_errors();
    $display("%0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- test/kc_periph_assertions.sv
// Concurrent checks on the Wishbone response and the UART line, bound to kc_periph_top
`timescale 1ns/100ps

module kc_periph_assertions (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_wb_cyc,
  input logic i_wb_stb,
  input logic i_wb_ack,
  input logic i_wb_err,
  input logic i_uart_td
);

  ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_wb_ack && i_wb_err))
    else $error("ack and err high in the same cycle");

  // Slave answers only a live cycle
  resp_in_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wb_ack || i_wb_err) |-> (i_wb_cyc && i_wb_stb))
    else $error("response without cyc and stb");

  resp_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wb_ack || i_wb_err) |=> !(i_wb_ack || i_wb_err))
    else $error("response held for more than one cycle");

  td_idle_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> i_uart_td)
    else $error("UART line not idle high out of reset");

endmodule

bind kc_periph_top kc_periph_assertions i_assert (
  .i_clk     (i_clk),
  .i_rst_n   (i_rst_n),
  .i_wb_cyc  (i_wb_cyc),
  .i_wb_stb  (i_wb_stb),
  .i_wb_ack  (o_wb_ack),
  .i_wb_err  (o_wb_err),
  .i_uart_td (o_uart_td)
);

//--- source/kc_periph_top.sv
// Peripheral subsystem top with address decode, GPIO, UART TX and response stage
`timescale 1ns/100ps

module kc_periph_top (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  // Wishbone classic slave
  input  logic                             i_wb_cyc,
  input  logic                             i_wb_stb,
  input  logic                             i_wb_we,
  input  logic [kc_periph_pkg::WB_AW-1:0]  i_wb_adr,
  input  logic [kc_periph_pkg::WB_DW-1:0]  i_wb_dat,
  output logic [kc_periph_pkg::WB_DW-1:0]  o_wb_dat,
  output logic                             o_wb_ack,
  output logic                             o_wb_err,
  // GPIO pins, [11:4] LEDs and [3:0] DIP switches
  input  logic [kc_periph_pkg::GPIO_W-1:0] i_gpio,
  output logic [kc_periph_pkg::GPIO_W-1:0] o_gpio,
  output logic [kc_periph_pkg::GPIO_W-1:0] o_gpio_dir,
  // UART serial out
  output logic                             o_uart_td
);
  import kc_periph_pkg::*;

  logic                 w_req_gpio;
  logic                 w_req_uart;
  logic                 w_req_none;
  logic                 w_we;
  logic [REG_IDX_W-1:0] wb_idx;
  logic                 w_gpio_ready;
  logic                 w_uart_ready;
  logic [WB_DW-1:0]     wb_gpio_rdata;
  logic [WB_DW-1:0]     wb_uart_rdata;
  logic                 w_resp_busy;

  periph_addr_decode dec0 (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_resp_busy (w_resp_busy),
    .o_req_gpio  (w_req_gpio),
    .o_req_uart  (w_req_uart),
    .o_req_none  (w_req_none),
    .o_we        (w_we),
    .o_idx       (wb_idx)
  );

  gpio_regs gpio0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_req      (w_req_gpio),
    .i_we       (w_we),
    .i_idx      (wb_idx),
    .i_wdata    (i_wb_dat),
    .i_gpio     (i_gpio),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir),
    .o_rdata    (wb_gpio_rdata),
    .o_ready    (w_gpio_ready)
  );

  uart_tx_engine uart0 (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_req     (w_req_uart),
    .i_we      (w_we),
    .i_idx     (wb_idx),
    .i_wdata   (i_wb_dat),
    .o_rdata   (wb_uart_rdata),
    .o_ready   (w_uart_ready),
    .o_uart_td (o_uart_td)
  );

  wb_read_return resp0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_req_gpio   (w_req_gpio),
    .i_req_uart   (w_req_uart),
    .i_req_none   (w_req_none),
    .i_we         (w_we),
    .i_idx        (wb_idx),
    .i_gpio_ready (w_gpio_ready),
    .i_uart_ready (w_uart_ready),
    .i_gpio_rdata (wb_gpio_rdata),
    .i_uart_rdata (wb_uart_rdata),
    .o_wb_ack     (o_wb_ack),
    .o_wb_err     (o_wb_err),
    .o_wb_dat     (o_wb_dat),
    .o_resp_busy  (w_resp_busy)
  );

endmodule

//--- source/wb_read_return.sv
// Wishbone response stage registering ack, err and read data
`timescale 1ns/100ps

module wb_read_return (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_req_gpio,
  input  logic                                i_req_uart,
  input  logic                                i_req_none,
  input  logic                                i_we,
  input  logic [kc_periph_pkg::REG_IDX_W-1:0] i_idx,
  input  logic                                i_gpio_ready,
  input  logic                                i_uart_ready,
  input  logic [kc_periph_pkg::WB_DW-1:0]     i_gpio_rdata,
  input  logic [kc_periph_pkg::WB_DW-1:0]     i_uart_rdata,
  output logic                                o_wb_ack,
  output logic                                o_wb_err,
  output logic [kc_periph_pkg::WB_DW-1:0]     o_wb_dat,
  output logic                                o_resp_busy
);
  import kc_periph_pkg::*;

  logic done;
  logic ro_write;
  logic err_d;
  logic ack_q;
  logic err_q;
  logic [WB_DW-1:0] dat_q;

  // A transfer ends when the addressed block is ready, or at once when unmapped
  assign done = (i_req_gpio & i_gpio_ready) | (i_req_uart & i_uart_ready) | i_req_none;

  assign ro_write = i_we & ((i_req_gpio & (i_idx == IDX_GPIO_IN)) |
                            (i_req_uart & (i_idx == IDX_UART_STATUS)));
  assign err_d    = i_req_none | ro_write;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= done & ~err_d;
      err_q <= done & err_d;
    end
  end

  always_ff @(posedge i_clk) begin
    if (done) begin
      dat_q <= i_req_gpio ? i_gpio_rdata : (i_req_uart ? i_uart_rdata : '0);
    end
  end

  assign o_wb_ack    = ack_q;
  assign o_wb_err    = err_q;
  assign o_wb_dat    = dat_q;
  // Masks decode for the cycle the response is on the bus
  assign o_resp_busy = ack_q | err_q;

endmodule

//--- source/uart_tx_engine.sv
// UART TXDATA, STATUS and DIV registers with the 8N1 transmit shift engine
`timescale 1ns/100ps

module uart_tx_engine (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_req,
  input  logic                                i_we,
  input  logic [kc_periph_pkg::REG_IDX_W-1:0] i_idx,
  input  logic [kc_periph_pkg::WB_DW-1:0]     i_wdata,
  output logic [kc_periph_pkg::WB_DW-1:0]     o_rdata,
  output logic                                o_ready,
  output logic                                o_uart_td
);
  import kc_periph_pkg::*;

  logic [UART_DIV_W-1:0]      div_q;
  logic [UART_DIV_W-1:0]      tick_q;
  logic [3:0]                 bit_cnt_q;
  logic [UART_FRAME_BITS-1:0] shift_q;
  logic                       busy_q;
  logic                       tx_wr;
  logic                       wr_en;
  logic                       tx_load;
  logic                       bit_end;

  assign tx_wr = i_req & i_we & (i_idx == IDX_UART_TXDATA);

  // Back-pressure: a new byte waits for the current frame
  assign o_ready = ~(tx_wr & busy_q);
  assign wr_en   = i_req & i_we & o_ready;
  assign tx_load = tx_wr & o_ready;
  assign bit_end = busy_q & (tick_q == '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      div_q <= UART_DIV_RESET;
    end else if (wr_en && (i_idx == IDX_UART_DIV)) begin
      div_q <= i_wdata[UART_DIV_W-1:0];
    end
  end

  // Bit timer and bit counter
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy_q    <= 1'b0;
      tick_q    <= '0;
      bit_cnt_q <= '0;
    end else if (tx_load) begin
      busy_q    <= 1'b1;
      tick_q    <= div_q;
      bit_cnt_q <= '0;
    end else if (bit_end) begin
      tick_q <= div_q;
      if (bit_cnt_q == 4'(UART_FRAME_BITS - 1)) begin
        // Stop bit done
        busy_q <= 1'b0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
    end else if (busy_q) begin
      tick_q <= tick_q - UART_DIV_W'(1);
    end
  end

  // Frame is stop, data LSB first, start, shifted out from bit 0
  always_ff @(posedge i_clk) begin
    if (tx_load) begin
      shift_q <= {1'b1, i_wdata[7:0], 1'b0};
    end else if (bit_end) begin
      shift_q <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
    end
  end

  // Line idles high
  assign o_uart_td = busy_q ? shift_q[0] : 1'b1;

  always_comb begin
    case (i_idx)
      IDX_UART_STATUS: o_rdata = {{(WB_DW-1){1'b0}}, busy_q};
      IDX_UART_DIV:    o_rdata = {{(WB_DW-UART_DIV_W){1'b0}}, div_q};
      default:         o_rdata = '0;
    endcase
  end

endmodule

//--- source/gpio_regs.sv
// GPIO output and direction registers, 2-flop input synchronizer and read mux
`timescale 1ns/100ps

module gpio_regs (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_req,
  input  logic                                i_we,
  input  logic [kc_periph_pkg::REG_IDX_W-1:0] i_idx,
  input  logic [kc_periph_pkg::WB_DW-1:0]     i_wdata,
  input  logic [kc_periph_pkg::GPIO_W-1:0]    i_gpio,
  output logic [kc_periph_pkg::GPIO_W-1:0]    o_gpio,
  output logic [kc_periph_pkg::GPIO_W-1:0]    o_gpio_dir,
  output logic [kc_periph_pkg::WB_DW-1:0]     o_rdata,
  output logic                                o_ready
);
  import kc_periph_pkg::*;

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] dir_q;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic              wr_en;
  gpio_word_u        wr_word;
  gpio_word_u        rd_word;

  // Registers never stall the bus
  assign o_ready = 1'b1;
  assign wr_en   = i_req & i_we & o_ready;

  assign wr_word.raw = i_wdata;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_en) begin
      if (i_idx == IDX_GPIO_OUT) begin
        out_q <= {wr_word.fields.leds, wr_word.fields.dips};
      end
      if (i_idx == IDX_GPIO_DIR) begin
        dir_q <= {wr_word.fields.leds, wr_word.fields.dips};
      end
    end
  end

  // Pins are asynchronous to i_clk
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= i_gpio;
      sync2_q <= sync1_q;
    end
  end

  always_comb begin
    rd_word.raw = '0;
    case (i_idx)
      IDX_GPIO_OUT: {rd_word.fields.leds, rd_word.fields.dips} = out_q;
      IDX_GPIO_DIR: {rd_word.fields.leds, rd_word.fields.dips} = dir_q;
      // Input register shows the pins, not the driven outputs
      IDX_GPIO_IN:  {rd_word.fields.leds, rd_word.fields.dips} = sync2_q;
      default:      rd_word.raw = '0;
    endcase
  end

  assign o_rdata    = rd_word.raw;
  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;

endmodule

//--- source/periph_addr_decode.sv
// Wishbone address decoder producing block requests, write flag and register index
`timescale 1ns/100ps

module periph_addr_decode (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_wb_cyc,
  input  logic                           i_wb_stb,
  input  logic                           i_wb_we,
  input  logic [kc_periph_pkg::WB_AW-1:0] i_wb_adr,
  input  logic                           i_resp_busy,
  output logic                           o_req_gpio,
  output logic                           o_req_uart,
  output logic                           o_req_none,
  output logic                           o_we,
  output logic [kc_periph_pkg::REG_IDX_W-1:0] o_idx
);
  import kc_periph_pkg::*;

  logic                 cyc_stb;
  logic                 live;
  logic [2:0]           sel_c;
  logic [2:0]           sel_q;
  logic [REG_IDX_W-1:0] idx_q;
  logic                 held_q;
  logic [2:0]           sel;

  assign cyc_stb = i_wb_cyc & i_wb_stb;
  // No request during the response cycle
  assign live = cyc_stb & ~i_resp_busy;

  // Select order is {gpio, uart, none}
  always_comb begin
    sel_c = 3'b001;
    if ((i_wb_adr == REG_GPIO_OUT) || (i_wb_adr == REG_GPIO_DIR) ||
        (i_wb_adr == REG_GPIO_IN)) begin
      sel_c = 3'b100;
    end else if ((i_wb_adr == REG_UART_TXDATA) || (i_wb_adr == REG_UART_STATUS) ||
                 (i_wb_adr == REG_UART_DIV)) begin
      sel_c = 3'b010;
    end
  end

  // Decode is taken on the first cycle of a transfer and kept while the UART stalls it
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      held_q <= 1'b0;
    end else begin
      held_q <= live;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!held_q) begin
      sel_q <= sel_c;
      idx_q <= i_wb_adr[4:2];
    end
  end

  assign sel = held_q ? sel_q : sel_c;

  assign o_req_gpio = live & sel[2];
  assign o_req_uart = live & sel[1];
  assign o_req_none = live & sel[0];
  assign o_we       = i_wb_we;
  assign o_idx      = held_q ? idx_q : i_wb_adr[4:2];

endmodule

//--- source/kc_periph_pkg.sv
// Register map, bus and pin widths, UART reset divisor and the GPIO word union
package kc_periph_pkg;

  // Wishbone widths
  localparam int WB_AW = 8;
  localparam int WB_DW = 32;

  // GPIO pins, [11:4] LEDs and [3:0] DIP switches
  localparam int GPIO_W = 12;
  localparam int LED_W  = 8;
  localparam int DIP_W  = 4;

  // Register index is address bits [4:2]
  localparam int REG_IDX_W = 3;

  // Register byte addresses
  localparam logic [WB_AW-1:0] REG_GPIO_OUT    = 8'h00;
  localparam logic [WB_AW-1:0] REG_GPIO_DIR    = 8'h04;
  localparam logic [WB_AW-1:0] REG_GPIO_IN     = 8'h08;
  localparam logic [WB_AW-1:0] REG_UART_TXDATA = 8'h10;
  localparam logic [WB_AW-1:0] REG_UART_STATUS = 8'h14;
  localparam logic [WB_AW-1:0] REG_UART_DIV    = 8'h18;

  // Register indexes as seen by the blocks
  localparam logic [REG_IDX_W-1:0] IDX_GPIO_OUT    = REG_GPIO_OUT[4:2];
  localparam logic [REG_IDX_W-1:0] IDX_GPIO_DIR    = REG_GPIO_DIR[4:2];
  localparam logic [REG_IDX_W-1:0] IDX_GPIO_IN     = REG_GPIO_IN[4:2];
  localparam logic [REG_IDX_W-1:0] IDX_UART_TXDATA = REG_UART_TXDATA[4:2];
  localparam logic [REG_IDX_W-1:0] IDX_UART_STATUS = REG_UART_STATUS[4:2];
  localparam logic [REG_IDX_W-1:0] IDX_UART_DIV    = REG_UART_DIV[4:2];

  // UART bit divisor, bit time is divisor+1 clocks
  localparam int UART_DIV_W = 16;
  localparam logic [UART_DIV_W-1:0] UART_DIV_RESET = 16'd3;

  // Start bit, 8 data bits, stop bit
  localparam int UART_FRAME_BITS = 10;

  // GPIO register word, either raw or split into LED and DIP fields
  typedef union packed {
    logic [WB_DW-1:0] raw;
    struct packed {
      logic [WB_DW-GPIO_W-1:0] rsvd;
      logic [LED_W-1:0]        leds;
      logic [DIP_W-1:0]        dips;
    } fields;
  } gpio_word_u;

endpackage
